// ==== common/twiddle_pkg.sv ====
package twiddle_pkg;

	// sample and twiddle widths
	localparam int DATA_W  = 18;
	localparam int TW_W    = 16;
	localparam int TW_FRAC = 14;

	// full product of one sample and one twiddle component
	localparam int PROD_W  = DATA_W + TW_W;

	// butterfly legs per beat, leg 0 is never multiplied
	localparam int LEGS    = 5;

	// index into the 64-point base table
	localparam int IDX_W   = 6;
	localparam int RADIX_W = 3;

	// pipeline depths, counted from the edge that samples in_val
	localparam int TW_LAT    = 5;
	localparam int LANE_LAT  = 8;
	localparam int STAGE_LAT = 9;

	localparam string TW_ROM_FILE = "hw/twiddle_rom.hex";

	typedef logic signed [DATA_W-1:0]  sample_t;
	typedef logic signed [TW_W-1:0]    twid_t;
	typedef logic        [IDX_W-1:0]   tw_index_t;
	typedef logic        [RADIX_W-1:0] radix_t;
	typedef logic signed [PROD_W-1:0]  prod_t;

	// round half up in Q14, caller keeps the low bits it needs
	function automatic prod_t round_frac(input prod_t x);
		prod_t half;
		half = prod_t'(1) <<< (TW_FRAC - 1);
		return (x + half) >>> TW_FRAC;
	endfunction

endpackage

// ==== hw/twiddle_source.sv ====
`timescale 1ns/1ps

module twiddle_source
	import twiddle_pkg::*;
(
	input  logic      clk,
	input  tw_index_t tw_index,
	output twid_t     tw_re [1:LEGS-1],
	output twid_t     tw_im [1:LEGS-1]
);

	// cosine in the upper word, negated sine in the lower
	logic [2*TW_W-1:0] rom [2**IDX_W];

	initial begin
		$readmemh(TW_ROM_FILE, rom);
	end

	// stage 1: base twiddle W
	twid_t w1_re;
	twid_t w1_im;

	// stage 2: W*W partial products, W carried along
	prod_t p2_rr;
	prod_t p2_ii;
	prod_t p2_ri;
	twid_t w1_re_d2;
	twid_t w1_im_d2;

	// stage 3: reduced W^2
	twid_t w2_re;
	twid_t w2_im;
	twid_t w1_re_d3;
	twid_t w1_im_d3;

	// stage 4: W*W^2 and W^2*W^2 partial products
	prod_t p3_rr;
	prod_t p3_ii;
	prod_t p3_ri;
	prod_t p3_ir;
	prod_t p4_rr;
	prod_t p4_ii;
	prod_t p4_ri;
	twid_t w1_re_d4;
	twid_t w1_im_d4;
	twid_t w2_re_d4;
	twid_t w2_im_d4;

	always_ff @(posedge clk) begin
		w1_re <= twid_t'(rom[tw_index][2*TW_W-1:TW_W]);
		w1_im <= twid_t'(rom[tw_index][TW_W-1:0]);
	end

	always_ff @(posedge clk) begin
		p2_rr    <= w1_re * w1_re;
		p2_ii    <= w1_im * w1_im;
		p2_ri    <= w1_re * w1_im;
		w1_re_d2 <= w1_re;
		w1_im_d2 <= w1_im;
	end

	// imag of a square is the cross term counted twice
	always_ff @(posedge clk) begin
		w2_re    <= twid_t'(round_frac(p2_rr - p2_ii));
		w2_im    <= twid_t'(round_frac(p2_ri + p2_ri));
		w1_re_d3 <= w1_re_d2;
		w1_im_d3 <= w1_im_d2;
	end

	always_ff @(posedge clk) begin
		p3_rr    <= w1_re_d3 * w2_re;
		p3_ii    <= w1_im_d3 * w2_im;
		p3_ri    <= w1_re_d3 * w2_im;
		p3_ir    <= w1_im_d3 * w2_re;
		p4_rr    <= w2_re * w2_re;
		p4_ii    <= w2_im * w2_im;
		p4_ri    <= w2_re * w2_im;
		w1_re_d4 <= w1_re_d3;
		w1_im_d4 <= w1_im_d3;
		w2_re_d4 <= w2_re;
		w2_im_d4 <= w2_im;
	end

	// stage 5: all four powers leave together
	always_ff @(posedge clk) begin
		tw_re[1] <= w1_re_d4;
		tw_im[1] <= w1_im_d4;
		tw_re[2] <= w2_re_d4;
		tw_im[2] <= w2_im_d4;
		tw_re[3] <= twid_t'(round_frac(p3_rr - p3_ii));
		tw_im[3] <= twid_t'(round_frac(p3_ri + p3_ir));
		tw_re[4] <= twid_t'(round_frac(p4_rr - p4_ii));
		tw_im[4] <= twid_t'(round_frac(p4_ri + p4_ri));
	end

endmodule

// ==== cmul_lane/cmul_lane.sv ====
`timescale 1ns/1ps

module cmul_lane
	import twiddle_pkg::*;
(
	input  logic    clk,
	input  sample_t din_re,
	input  sample_t din_im,
	input  twid_t   tw_re,
	input  twid_t   tw_im,
	output sample_t prod_re,
	output sample_t prod_im
);

	// sample delay line, last tap lines up with the twiddle powers
	sample_t dly_re [TW_LAT];
	sample_t dly_im [TW_LAT];

	// partial products, one per operand pair
	prod_t pp_rr;
	prod_t pp_ii;
	prod_t pp_ri;
	prod_t pp_ir;

	// complex difference and sum at full width
	prod_t sum_re;
	prod_t sum_im;

	sample_t d_re;
	sample_t d_im;

	assign d_re = dly_re[TW_LAT-1];
	assign d_im = dly_im[TW_LAT-1];

	always_ff @(posedge clk) begin
		dly_re[0] <= din_re;
		dly_im[0] <= din_im;
		for (int s = 1; s < TW_LAT; s++) begin
			dly_re[s] <= dly_re[s-1];
			dly_im[s] <= dly_im[s-1];
		end
	end

	// cycle 6
	always_ff @(posedge clk) begin
		pp_rr <= d_re * tw_re;
		pp_ii <= d_im * tw_im;
		pp_ri <= d_re * tw_im;
		pp_ir <= d_im * tw_re;
	end

	// cycle 7
	always_ff @(posedge clk) begin
		sum_re <= pp_rr - pp_ii;
		sum_im <= pp_ri + pp_ir;
	end

	// cycle 8, wraps into the sample width on overflow
	always_ff @(posedge clk) begin
		prod_re <= sample_t'(round_frac(sum_re));
		prod_im <= sample_t'(round_frac(sum_im));
	end

endmodule

// ==== hw/lane_collect.sv ====
`timescale 1ns/1ps

module lane_collect
	import twiddle_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_val,
	input  radix_t  radix,
	input  sample_t leg0_re,
	input  sample_t leg0_im,
	input  sample_t prod_re [1:LEGS-1],
	input  sample_t prod_im [1:LEGS-1],
	output logic    out_val,
	output sample_t dout_re [LEGS],
	output sample_t dout_im [LEGS]
);

	logic [LANE_LAT-1:0] val_sr;
	radix_t              radix_sr [LANE_LAT];
	sample_t             leg0_re_sr [LANE_LAT];
	sample_t             leg0_im_sr [LANE_LAT];

	logic   val_last;
	radix_t radix_last;
	logic   [LEGS-1:0] leg_on;

	assign val_last   = val_sr[LANE_LAT-1];
	assign radix_last = radix_sr[LANE_LAT-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_sr <= '0;
		end else begin
			val_sr <= {val_sr[LANE_LAT-2:0], in_val};
		end
	end

	// radix and leg 0 follow the valid bit
	always_ff @(posedge clk) begin
		radix_sr[0]   <= radix;
		leg0_re_sr[0] <= leg0_re;
		leg0_im_sr[0] <= leg0_im;
		for (int s = 1; s < LANE_LAT; s++) begin
			radix_sr[s]   <= radix_sr[s-1];
			leg0_re_sr[s] <= leg0_re_sr[s-1];
			leg0_im_sr[s] <= leg0_im_sr[s-1];
		end
	end

	// a leg is live below the radix, and only on a valid slot
	always_comb begin
		leg_on[0] = val_last;
		for (int l = 1; l < LEGS; l++) begin
			leg_on[l] = val_last && (radix_t'(l) < radix_last);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val <= 1'b0;
		end else begin
			out_val <= val_last;
		end
	end

	always_ff @(posedge clk) begin
		dout_re[0] <= leg_on[0] ? leg0_re_sr[LANE_LAT-1] : '0;
		dout_im[0] <= leg_on[0] ? leg0_im_sr[LANE_LAT-1] : '0;
		for (int l = 1; l < LEGS; l++) begin
			dout_re[l] <= leg_on[l] ? prod_re[l] : '0;
			dout_im[l] <= leg_on[l] ? prod_im[l] : '0;
		end
	end

	// only radix 2 to 5 is supported by the stage
	radix_legal: assert property (@(posedge clk) disable iff (!rst_n)
		in_val |-> (radix >= radix_t'(2) && radix <= radix_t'(5)));

	// every output beat traces back to a beat at the stage input
	no_spurious_val: assert property (@(posedge clk) disable iff (!rst_n)
		!in_val |-> ##STAGE_LAT !out_val);

endmodule

// ==== hw/twiddle_stage.sv ====
`timescale 1ns/1ps

module twiddle_stage
	import twiddle_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_val,
	input  tw_index_t tw_index,
	input  radix_t    radix,
	input  sample_t   din_re [LEGS],
	input  sample_t   din_im [LEGS],
	output logic      out_val,
	output sample_t   dout_re [LEGS],
	output sample_t   dout_im [LEGS]
);

	// twiddle powers W^1 to W^4
	twid_t tw_re [1:LEGS-1];
	twid_t tw_im [1:LEGS-1];

	// rounded lane products, one per multiplied leg
	sample_t prod_re [1:LEGS-1];
	sample_t prod_im [1:LEGS-1];

	twiddle_source twiddle_source_inst (
		.clk      (clk),
		.tw_index (tw_index),
		.tw_re    (tw_re),
		.tw_im    (tw_im)
	);

	// leg i is multiplied by W^i
	for (genvar g = 1; g < LEGS; g++) begin : gen_lane
		cmul_lane cmul_lane_inst (
			.clk     (clk),
			.din_re  (din_re[g]),
			.din_im  (din_im[g]),
			.tw_re   (tw_re[g]),
			.tw_im   (tw_im[g]),
			.prod_re (prod_re[g]),
			.prod_im (prod_im[g])
		);
	end

	lane_collect lane_collect_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_val  (in_val),
		.radix   (radix),
		.leg0_re (din_re[0]),
		.leg0_im (din_im[0]),
		.prod_re (prod_re),
		.prod_im (prod_im),
		.out_val (out_val),
		.dout_re (dout_re),
		.dout_im (dout_im)
	);

endmodule

// ==== bench/twiddle_model.svh ====
`ifndef TWIDDLE_MODEL_SVH
`define TWIDDLE_MODEL_SVH

// base table, cosine word over negated sine word
logic [2*TW_W-1:0] tw_table [2**IDX_W];

task automatic load_twiddle_table();
	$readmemh(TW_ROM_FILE, tw_table);
endtask

// keep the low bits as a signed value of the given width
function automatic longint wrap_to(input longint x, input int width);
	longint mask;
	longint v;
	mask = (longint'(1) <<< width) - 1;
	v = x & mask;
	if (v >= (longint'(1) <<< (width - 1))) begin
		v = v - (longint'(1) <<< width);
	end
	return v;
endfunction

// add half an lsb, drop 14 fraction bits, then wrap
function automatic longint reduce_q14(input longint x, input int width);
	return wrap_to((x + 8192) >>> 14, width);
endfunction

// full-width complex sum first, one reduction per component
function automatic void cmul_q14(input longint ar, input longint ai, input longint br,
		input longint bi, input int width, output longint cr, output longint ci);
	cr = reduce_q14(ar * br - ai * bi, width);
	ci = reduce_q14(ar * bi + ai * br, width);
endfunction

function automatic void twiddle_power(input tw_index_t k, input int p,
		output longint pw_re, output longint pw_im);
	longint wr [1:4];
	longint wi [1:4];
	wr[1] = wrap_to(longint'(tw_table[k][2*TW_W-1:TW_W]), TW_W);
	wi[1] = wrap_to(longint'(tw_table[k][TW_W-1:0]), TW_W);
	cmul_q14(wr[1], wi[1], wr[1], wi[1], TW_W, wr[2], wi[2]);
	cmul_q14(wr[1], wi[1], wr[2], wi[2], TW_W, wr[3], wi[3]);
	// W^4 from W^2 squared, not from W^3
	cmul_q14(wr[2], wi[2], wr[2], wi[2], TW_W, wr[4], wi[4]);
	pw_re = wr[p];
	pw_im = wi[p];
endfunction

// one leg of one beat: zero above the radix, pass-through on leg 0
function automatic void expected_leg(input tw_index_t k, input int r, input int leg,
		input longint dre, input longint dim, output longint ere, output longint eim);
	longint tr;
	longint ti;
	if (leg >= r) begin
		ere = 0;
		eim = 0;
	end else if (leg == 0) begin
		ere = dre;
		eim = dim;
	end else begin
		twiddle_power(k, leg, tr, ti);
		cmul_q14(dre, dim, tr, ti, DATA_W, ere, eim);
	end
endfunction

`endif

// ==== bench/tb_twiddle_stage.sv ====
`timescale 1ns/1ps

module tb_twiddle_stage
	import twiddle_pkg::*;
();

	logic      clk;
	logic      rst_n;
	logic      in_val;
	tw_index_t tw_index;
	radix_t    radix;
	sample_t   din_re [LEGS];
	sample_t   din_im [LEGS];
	logic      out_val;
	sample_t   dout_re [LEGS];
	sample_t   dout_im [LEGS];

	int     cycle = 0;
	logic   mon_en = 1'b0;
	int     err_cnt = 0;
	int     beat_cnt = 0;
	int     test_cnt = 0;
	// due cycle per beat, and ten expected values per beat
	int     exp_due [$];
	longint exp_vals [$];
	longint stim_re [LEGS];
	longint stim_im [LEGS];

	`include "twiddle_model.svh"

	twiddle_stage twiddle_stage_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_val   (in_val),
		.tw_index (tw_index),
		.radix    (radix),
		.din_re   (din_re),
		.din_im   (din_im),
		.out_val  (out_val),
		.dout_re  (dout_re),
		.dout_im  (dout_im)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic check_value(input string name, input logic signed [63:0] exp_v,
			input logic signed [63:0] act_v);
		if (exp_v !== act_v) begin
			err_cnt++;
			$display("ERROR at %0t: %s expected %0d, actual %0d", $time, name, exp_v, act_v);
		end
	endtask

	// a beat due now must be on the outputs, otherwise everything idles at zero
	task automatic check_output_slot();
		longint er;
		longint ei;
		if (exp_due.size() > 0 && exp_due[0] == cycle) begin
			exp_due.delete(0);
			check_value("out_val", 64'sd1, 64'(out_val));
			for (int l = 0; l < LEGS; l++) begin
				er = exp_vals.pop_front();
				ei = exp_vals.pop_front();
				check_value($sformatf("dout_re[%0d]", l), er, 64'(dout_re[l]));
				check_value($sformatf("dout_im[%0d]", l), ei, 64'(dout_im[l]));
			end
			beat_cnt++;
		end else begin
			check_value("out_val", 64'sd0, 64'(out_val));
			for (int l = 0; l < LEGS; l++) begin
				check_value($sformatf("dout_re[%0d]", l), 64'sd0, 64'(dout_re[l]));
				check_value($sformatf("dout_im[%0d]", l), 64'sd0, 64'(dout_im[l]));
			end
		end
	endtask

	always @(posedge clk) begin
		if (mon_en) begin
			check_output_slot();
		end
	end

	function automatic longint rand_sample();
		sample_t s;
		s = sample_t'($urandom);
		return longint'(s);
	endfunction

	task automatic fill_random_samples();
		for (int l = 0; l < LEGS; l++) begin
			stim_re[l] = rand_sample();
			stim_im[l] = rand_sample();
		end
	endtask

	// sampled by the DUT one edge later, so the beat is due STAGE_LAT after that
	task automatic send_beat(input int k, input int r);
		longint er;
		longint ei;
		in_val   <= 1'b1;
		tw_index <= tw_index_t'(k);
		radix    <= radix_t'(r);
		for (int l = 0; l < LEGS; l++) begin
			din_re[l] <= sample_t'(stim_re[l]);
			din_im[l] <= sample_t'(stim_im[l]);
			expected_leg(tw_index_t'(k), r, l, stim_re[l], stim_im[l], er, ei);
			exp_vals.push_back(er);
			exp_vals.push_back(ei);
		end
		exp_due.push_back(cycle + 1 + STAGE_LAT);
		@(posedge clk);
	endtask

	// idle slots still carry random data, which must not leak out
	task automatic send_idle(input int n);
		for (int i = 0; i < n; i++) begin
			in_val   <= 1'b0;
			tw_index <= tw_index_t'($urandom);
			radix    <= radix_t'($urandom);
			for (int l = 0; l < LEGS; l++) begin
				din_re[l] <= sample_t'($urandom);
				din_im[l] <= sample_t'($urandom);
			end
			@(posedge clk);
		end
	endtask

	// up to 50 cycles for the monitor to consume the last beat of the test
	task automatic wait_drain();
		int waited;
		waited = 0;
		in_val <= 1'b0;
		while (exp_due.size() != 0 && waited < 50) begin
			@(posedge clk);
			waited++;
		end
		if (exp_due.size() != 0) begin
			err_cnt++;
			$display("timeout: %0d beats still waiting for out_val after %0d cycles",
				exp_due.size(), waited);
		end
	endtask

	task automatic report_test(input string name, input int err0, input int beat0);
		test_cnt++;
		$display("%s: %0d beats checked, %0d errors, %s", name, beat_cnt - beat0,
			err_cnt - err0, (err_cnt == err0) ? "ok" : "MISMATCH");
	endtask

	task automatic run_unity();
		int err0;
		int beat0;
		err0 = err_cnt;
		beat0 = beat_cnt;
		for (int i = 0; i < 20; i++) begin
			fill_random_samples();
			send_beat(0, 5);
		end
		wait_drain();
		report_test("unity_twiddle", err0, beat0);
	endtask

	task automatic run_random_stream();
		int err0;
		int beat0;
		err0 = err_cnt;
		beat0 = beat_cnt;
		for (int i = 0; i < 300; i++) begin
			fill_random_samples();
			send_beat($urandom_range(63, 0), $urandom_range(5, 2));
		end
		wait_drain();
		report_test("random_stream", err0, beat0);
	endtask

	task automatic run_radix_mask();
		int err0;
		int beat0;
		err0 = err_cnt;
		beat0 = beat_cnt;
		for (int r = 2; r <= 5; r++) begin
			for (int i = 0; i < 12; i++) begin
				fill_random_samples();
				send_beat($urandom_range(63, 0), r);
			end
		end
		wait_drain();
		report_test("radix_mask", err0, beat0);
	endtask

	task automatic run_full_scale();
		int err0;
		int beat0;
		int idx [3];
		longint hi;
		longint lo;
		err0 = err_cnt;
		beat0 = beat_cnt;
		idx = '{8, 16, 40};
		hi = (longint'(1) <<< (DATA_W - 1)) - 1;
		lo = -(longint'(1) <<< (DATA_W - 1));
		for (int i = 0; i < 3; i++) begin
			// both corners and both mixed-sign corners
			for (int p = 0; p < 4; p++) begin
				for (int l = 0; l < LEGS; l++) begin
					stim_re[l] = (p == 0 || p == 2) ? hi : lo;
					stim_im[l] = (p == 0 || p == 3) ? hi : lo;
				end
				send_beat(idx[i], 5);
			end
		end
		wait_drain();
		report_test("full_scale", err0, beat0);
	endtask

	task automatic run_timing_gaps();
		int err0;
		int beat0;
		err0 = err_cnt;
		beat0 = beat_cnt;
		// beats caught in the pipeline by reset must never reach out_val
		for (int i = 0; i < 3; i++) begin
			fill_random_samples();
			in_val   <= 1'b1;
			tw_index <= tw_index_t'($urandom);
			radix    <= radix_t'($urandom_range(5, 2));
			for (int l = 0; l < LEGS; l++) begin
				din_re[l] <= sample_t'(stim_re[l]);
				din_im[l] <= sample_t'(stim_im[l]);
			end
			@(posedge clk);
		end
		in_val <= 1'b0;
		rst_n  <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		send_idle(STAGE_LAT + 1);
		for (int i = 0; i < 100; i++) begin
			fill_random_samples();
			send_beat($urandom_range(63, 0), $urandom_range(5, 2));
			send_idle($urandom_range(4, 0));
		end
		wait_drain();
		report_test("timing_gaps", err0, beat0);
	endtask

	initial begin
		void'($urandom(29640));
		rst_n    = 1'b0;
		in_val   = 1'b0;
		tw_index = '0;
		radix    = radix_t'(2);
		for (int l = 0; l < LEGS; l++) begin
			din_re[l] = '0;
			din_im[l] = '0;
		end
		load_twiddle_table();
		repeat (2) @(posedge clk);
		rst_n  <= 1'b1;
		mon_en <= 1'b1;
		@(posedge clk);
		run_unity();
		run_random_stream();
		run_radix_mask();
		run_full_scale();
		run_timing_gaps();
		$display("summary: %0d tests, %0d beats checked, %0d errors",
			test_cnt, beat_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== hw/twiddle_rom.hex ====
// columns: cosine word (upper 16 bits), negated sine word (lower 16 bits)
// Q2.14 two's complement, one line per twiddle index 0 to 63
40000000
3FB1F9BA
3EC5F384
3D3FED6C
3B21E782
3871E1D5
3537DC72
3179D766
2D41D2BF
289ACE87
238ECAC9
1E2BC78F
187EC4DF
1294C2C1
0C7CC13B
0646C04F
0000C000
F9BAC04F
F384C13B
ED6CC2C1
E782C4DF
E1D5C78F
DC72CAC9
D766CE87
D2BFD2BF
CE87D766
CAC9DC72
C78FE1D5
C4DFE782
C2C1ED6C
C13BF384
C04FF9BA
C0000000
C04F0646
C13B0C7C
C2C11294
C4DF187E
C78F1E2B
CAC9238E
CE87289A
D2BF2D41
D7663179
DC723537
E1D53871
E7823B21
ED6C3D3F
F3843EC5
F9BA3FB1
00004000
06463FB1
0C7C3EC5
12943D3F
187E3B21
1E2B3871
238E3537
289A3179
2D412D41
3179289A
3537238E
38711E2B
3B21187E
3D3F1294
3EC50C7C
3FB10646

// ==== twiddle_stage.f ====
+incdir+bench
common/twiddle_pkg.sv
hw/twiddle_source.sv
cmul_lane/cmul_lane.sv
hw/lane_collect.sv
hw/twiddle_stage.sv
bench/tb_twiddle_stage.sv

// ==== Makefile ====
# Verilator build and run for the twiddle stage testbench

TOP = tb_twiddle_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f twiddle_stage.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
